// File: rtl/wb_settings.svh
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// Width of one AXI write-data beat
`define WB_WORD_BITS 32

`define WB_LINE_WORDS 16

`define WB_ADDR_BITS 32

`endif

// File: rtl/wb_pkg.sv
`include "wb_settings.svh"

package wb_pkg;

    // Word 0 of the line sits in the low bits
    typedef logic [`WB_LINE_WORDS-1:0][`WB_WORD_BITS-1:0] line_t;

    typedef struct packed {
        logic [`WB_ADDR_BITS-1:0] addr;
        logic                     uncache;  // Single-word store, no line fill
    } wb_req_t;

    typedef struct packed {
        logic [`WB_ADDR_BITS-1:0] awaddr;
        logic [7:0]               awlen;    // Beats minus one
        logic [2:0]               awsize;   // Log2 of bytes per beat
    } axi_aw_t;

    typedef struct packed {
        logic [`WB_WORD_BITS-1:0]   wdata;
        logic [`WB_WORD_BITS/8-1:0] wstrb;
        logic                       wlast;
    } axi_w_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

endpackage

// File: rtl/wb_line_buffer.sv
`timescale 1ns/1ps

module wb_line_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     load,
    input  payload_t din,
    output payload_t dout
);

    payload_t held;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            held <= '0;
        end else if (load) begin
            held <= din;  // Captured once per request, stays until the next load
        end
    end

    assign dout = held;

endmodule

// File: rtl/wb_request_unit.sv
`timescale 1ns/1ps
`include "wb_settings.svh"

module wb_request_unit
    import wb_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      wb_valid,
    input  logic      wb_ack,
    input  wb_req_t   req,
    input  logic      burst_done,
    input  axi_resp_t burst_resp,
    output logic      buf_load,
    output axi_aw_t   aw,
    output logic      awvalid,
    input  logic      awready,
    output logic      burst_start,
    output logic      wb_busy,
    output logic      wb_finish,
    output logic      wb_err
);

    localparam int LINE_OFS = $clog2(`WB_LINE_WORDS * `WB_WORD_BITS / 8);
    localparam int WORD_OFS = $clog2(`WB_WORD_BITS / 8);
    localparam logic [`WB_ADDR_BITS-1:0] LINE_MASK = {`WB_ADDR_BITS{1'b1}} << LINE_OFS;
    localparam logic [`WB_ADDR_BITS-1:0] WORD_MASK = {`WB_ADDR_BITS{1'b1}} << WORD_OFS;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        FINISH
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (wb_valid) begin
                    state_nxt = ADDR;
                end
            end
            ADDR: begin
                if (awready) begin
                    state_nxt = DATA;
                end
            end
            DATA: begin
                if (burst_done) begin
                    state_nxt = FINISH;
                end
            end
            FINISH: begin
                if (wb_ack) begin
                    state_nxt = IDLE;  // Cache has seen the result
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            burst_start <= 1'b0;
            wb_err      <= 1'b0;
        end else begin
            burst_start <= (state == ADDR) && awready;
            if (burst_done) begin
                wb_err <= (burst_resp != OKAY);
            end else if ((state == FINISH) && wb_ack) begin
                wb_err <= 1'b0;
            end
        end
    end

    // Header comes from the buffer, so the payload is stable while awvalid is up
    always_comb begin
        aw.awaddr = req.uncache ? (req.addr & WORD_MASK) : (req.addr & LINE_MASK);
        aw.awlen  = req.uncache ? 8'd0 : 8'(`WB_LINE_WORDS - 1);
        aw.awsize = 3'(WORD_OFS);
    end

    assign buf_load  = (state == IDLE) && wb_valid;
    assign awvalid   = (state == ADDR);
    assign wb_busy   = (state != IDLE);
    assign wb_finish = (state == FINISH);

endmodule

// File: rtl/wb_burst_writer.sv
`timescale 1ns/1ps
`include "wb_settings.svh"

module wb_burst_writer
    import wb_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      burst_start,
    input  wb_req_t   req,
    input  line_t     line,
    output axi_w_t    w,
    output logic      wvalid,
    input  logic      wready,
    input  axi_resp_t bresp,
    input  logic      bvalid,
    output logic      bready,
    output logic      burst_done,
    output axi_resp_t burst_resp
);

    localparam int CNT_BITS = $clog2(`WB_LINE_WORDS);
    localparam int LINE_OFS = $clog2(`WB_LINE_WORDS * `WB_WORD_BITS / 8);
    localparam int WORD_OFS = $clog2(`WB_WORD_BITS / 8);
    localparam logic [CNT_BITS-1:0] LAST_BEAT = CNT_BITS'(`WB_LINE_WORDS - 1);

    typedef enum logic [1:0] {
        IDLE,
        DATA,
        RESP
    } state_t;

    state_t              state;
    state_t              state_nxt;
    logic [CNT_BITS-1:0] beat_cnt;
    logic [CNT_BITS-1:0] word_sel;
    logic                w_fire;
    logic                b_fire;

    assign w_fire = wvalid && wready;
    assign b_fire = bvalid && bready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (burst_start) begin
                    state_nxt = DATA;
                end
            end
            DATA: begin
                if (w_fire && w.wlast) begin
                    state_nxt = RESP;
                end
            end
            RESP: begin
                if (bvalid) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // Counter only moves on an accepted beat, so a stalled beat keeps its word
    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_cnt <= '0;
        end else if (state == IDLE) begin
            beat_cnt <= '0;
        end else if (w_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            burst_done <= 1'b0;
        end else begin
            burst_done <= b_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (b_fire) begin
            burst_resp <= bresp;
        end
    end

    // An uncached store picks its word from the address offset
    assign word_sel = req.uncache ? req.addr[LINE_OFS-1:WORD_OFS] : beat_cnt;

    always_comb begin
        w.wdata = line[word_sel];
        w.wstrb = '1;
        w.wlast = req.uncache || (beat_cnt == LAST_BEAT);
    end

    assign wvalid = (state == DATA);
    assign bready = (state == RESP);

endmodule

// File: rtl/writeback_axi_top.sv
`timescale 1ns/1ps

module writeback_axi_top
    import wb_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      wb_valid,
    input  wb_req_t   wb_req,
    input  line_t     wb_line,
    input  logic      wb_ack,
    output logic      wb_busy,
    output logic      wb_finish,
    output logic      wb_err,
    output axi_aw_t   aw,
    output logic      awvalid,
    input  logic      awready,
    output axi_w_t    w,
    output logic      wvalid,
    input  logic      wready,
    input  axi_resp_t bresp,
    input  logic      bvalid,
    output logic      bready
);

    logic      buf_load;
    logic      burst_start;
    logic      burst_done;
    axi_resp_t burst_resp;
    line_t     line_q;
    wb_req_t   req_q;

    wb_request_unit u_request (
        .clk         (clk),
        .rstn        (rstn),
        .wb_valid    (wb_valid),
        .wb_ack      (wb_ack),
        .req         (req_q),
        .burst_done  (burst_done),
        .burst_resp  (burst_resp),
        .buf_load    (buf_load),
        .aw          (aw),
        .awvalid     (awvalid),
        .awready     (awready),
        .burst_start (burst_start),
        .wb_busy     (wb_busy),
        .wb_finish   (wb_finish),
        .wb_err      (wb_err)
    );

    wb_line_buffer #(.payload_t(line_t)) u_line_buf (
        .clk  (clk),
        .rstn (rstn),
        .load (buf_load),
        .din  (wb_line),
        .dout (line_q)
    );

    wb_line_buffer #(.payload_t(wb_req_t)) u_req_buf (
        .clk  (clk),
        .rstn (rstn),
        .load (buf_load),
        .din  (wb_req),
        .dout (req_q)
    );

    wb_burst_writer u_burst (
        .clk         (clk),
        .rstn        (rstn),
        .burst_start (burst_start),
        .req         (req_q),
        .line        (line_q),
        .w           (w),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .burst_done  (burst_done),
        .burst_resp  (burst_resp)
    );

endmodule

// File: verification/wb_axi_assertions.sv
`timescale 1ns/1ps

module wb_axi_assertions
    import wb_pkg::*;
(
    input logic      clk,
    input logic      rstn,
    input axi_aw_t   aw,
    input logic      awvalid,
    input logic      awready,
    input axi_w_t    w,
    input logic      wvalid,
    input logic      wready,
    input logic      bready,
    input logic      wb_finish,
    input logic      wb_ack
);

    aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("awvalid dropped or the address payload changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (!rstn)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("wvalid dropped or the data payload changed before wready");

    // The response phase never overlaps a data beat
    w_b_apart: assert property (@(posedge clk) disable iff (!rstn)
        !(wvalid && bready))
        else $error("wvalid and bready were high together");

    finish_hold: assert property (@(posedge clk) disable iff (!rstn)
        wb_finish && !wb_ack |=> wb_finish)
        else $error("wb_finish dropped without wb_ack");

endmodule

bind writeback_axi_top wb_axi_assertions u_assertions (
    .clk       (clk),
    .rstn      (rstn),
    .aw        (aw),
    .awvalid   (awvalid),
    .awready   (awready),
    .w         (w),
    .wvalid    (wvalid),
    .wready    (wready),
    .bready    (bready),
    .wb_finish (wb_finish),
    .wb_ack    (wb_ack)
);

// File: verification/writeback_axi_tb.sv
`timescale 1ns/1ps
`include "wb_settings.svh"

module writeback_axi_tb
    import wb_pkg::*;
();

    localparam int NUM_TESTS      = 8;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 60 + 20;

    typedef struct packed {
        logic [31:0] addr;
        logic        uncache;
        logic [31:0] pattern;
        axi_resp_t   resp;
    } stim_t;

    logic        clk;
    logic        rstn;
    logic        wb_valid;
    wb_req_t     wb_req;
    line_t       wb_line;
    logic        wb_ack;
    logic        wb_busy;
    logic        wb_finish;
    logic        wb_err;
    axi_aw_t     aw;
    logic        awvalid;
    logic        awready;
    axi_w_t      w;
    logic        wvalid;
    logic        wready;
    axi_resp_t   bresp;
    logic        bvalid;
    logic        bready;

    stim_t       stim [NUM_TESTS];
    axi_resp_t   cur_resp;
    axi_w_t      w_q [$];
    axi_aw_t     last_aw;
    int          aw_count;
    int          cycle_cnt;
    int          checks;
    int          errors;
    logic [15:0] lfsr;

    writeback_axi_top DUT (.*);

    always #2 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] line_word(input logic [31:0] pattern, input int k);
        return pattern ^ (32'(k) * 32'h0101_0101) ^ {28'h0, 4'(k)};
    endfunction

    function automatic line_t build_line(input logic [31:0] pattern);
        line_t l;
        for (int k = 0; k < `WB_LINE_WORDS; k++) begin
            l[k] = line_word(pattern, k);
        end
        return l;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error: %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Slave model with random stalls that records every AW and W transfer
    always @(posedge clk) begin
        lfsr = lfsr_step(lfsr);
        awready <= lfsr[0];
        lfsr = lfsr_step(lfsr);
        wready <= lfsr[0];
        if (awvalid && awready) begin
            aw_count = aw_count + 1;
            last_aw = aw;
        end
        if (wvalid && wready) begin
            w_q.push_back(w);
        end
        if (!rstn) begin
            bvalid <= 1'b0;
        end else if (bvalid && bready) begin
            bvalid <= 1'b0;
        end else if (wvalid && wready && w.wlast) begin
            bvalid <= 1'b1;  // Response follows the last beat
            bresp  <= cur_resp;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the DUT did not complete the tests in %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        stim_t       s;
        wb_req_t     req_v;
        wb_req_t     decoy;
        int          aw_start;
        int          w_start;
        int          n_beats;
        logic [31:0] exp_addr;
        logic [7:0]  exp_len;

        clk       = 1'b0;
        rstn      = 1'b0;
        wb_valid  = 1'b0;
        wb_req    = '0;
        wb_line   = '0;
        wb_ack    = 1'b0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        bresp     = OKAY;
        cur_resp  = OKAY;
        lfsr      = 16'd83;
        aw_count  = 0;
        cycle_cnt = 0;
        checks    = 0;
        errors    = 0;

        stim[0] = '{32'h0000_1000, 1'b0, 32'hA5A5_0000, OKAY};
        stim[1] = '{32'h0000_207C, 1'b0, 32'h1234_5600, OKAY};  // Unaligned line address
        stim[2] = '{32'h8000_0044, 1'b1, 32'h0BAD_F00D, OKAY};
        stim[3] = '{32'h0000_30BE, 1'b1, 32'h5A5A_1111, SLVERR};
        stim[4] = '{32'hFFFF_FFC0, 1'b0, 32'h7777_0000, DECERR};
        stim[5] = '{32'h0000_4013, 1'b1, 32'hC0DE_0042, EXOKAY};
        stim[6] = '{32'h0000_5008, 1'b0, 32'h0F0F_F0F0, SLVERR};
        stim[7] = '{32'h0000_6000, 1'b0, 32'h3C3C_C3C3, OKAY};

        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        check_value("awvalid", 32'(awvalid), 0);
        check_value("wvalid", 32'(wvalid), 0);
        check_value("bready", 32'(bready), 0);
        check_value("wb_finish", 32'(wb_finish), 0);
        check_value("wb_busy", 32'(wb_busy), 0);
        check_value("wb_err", 32'(wb_err), 0);

        for (int i = 0; i < NUM_TESTS; i++) begin
            s             = stim[i];
            cur_resp      = s.resp;
            req_v.addr    = s.addr;
            req_v.uncache = s.uncache;
            aw_start      = aw_count;
            w_start       = w_q.size();
            wb_valid <= 1'b1;
            wb_req   <= req_v;
            wb_line  <= build_line(s.pattern);
            @(posedge clk);
            wb_valid <= 1'b0;
            repeat (2) @(posedge clk);

            // A second strobe while busy must be ignored
            decoy.addr    = ~s.addr;
            decoy.uncache = ~s.uncache;
            checks++;
            assert (wb_busy) else begin
                errors++;
                $display("Request %0d was not accepted, wb_busy is still low", i);
            end
            wb_valid <= 1'b1;
            wb_req   <= decoy;
            wb_line  <= build_line(~s.pattern);
            @(posedge clk);
            wb_valid <= 1'b0;

            while (!wb_finish) @(posedge clk);
            check_value("wb_err", 32'(wb_err), 32'(s.resp != OKAY));
            wb_ack <= 1'b1;
            @(posedge clk);
            wb_ack <= 1'b0;
            @(posedge clk);
            check_value("wb_finish", 32'(wb_finish), 0);
            check_value("wb_busy", 32'(wb_busy), 0);
            check_value("wb_err", 32'(wb_err), 0);

            exp_addr = s.uncache ? (s.addr & ~32'h3) : (s.addr & ~32'h3F);
            exp_len  = s.uncache ? 8'd0 : 8'd15;
            check_value("aw transfers", aw_count - aw_start, 1);
            check_value("awaddr", last_aw.awaddr, exp_addr);
            check_value("awlen", 32'(last_aw.awlen), 32'(exp_len));
            check_value("awsize", 32'(last_aw.awsize), 2);
            n_beats = w_q.size() - w_start;
            check_value("beat count", n_beats, 32'(exp_len) + 1);
            for (int k = 0; k < n_beats && k <= int'(exp_len); k++) begin
                check_value("wdata", w_q[w_start + k].wdata,
                            line_word(s.pattern, s.uncache ? int'(s.addr[5:2]) : k));
                check_value("wlast", 32'(w_q[w_start + k].wlast), 32'(k == int'(exp_len)));
                check_value("wstrb", 32'(w_q[w_start + k].wstrb), 32'hF);
            end
        end

        $display("Closing report: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: writeback_axi.f
+incdir+rtl
rtl/wb_pkg.sv
rtl/wb_line_buffer.sv
rtl/wb_request_unit.sv
rtl/wb_burst_writer.sv
rtl/writeback_axi_top.sv
verification/wb_axi_assertions.sv
verification/writeback_axi_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = writeback_axi_tb
FILELIST  = writeback_axi.f
LOG       = sim.log

.PHONY: sim clean

# The run passes only if the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
